/* source/alu_pkg.sv */
// 4-bit opcode space is full, so bitwise NOT has no opcode (xor with all ones gives it)
`default_nettype none

package alu_pkg;

	// default widths for top level and testbench
	localparam int DATA_W_DEF = 32;
	localparam int ADDR_W_DEF = 16;  // pc width, must not exceed data width

	// top level opcodes
	typedef enum logic [3:0] {
		OP_AND, OP_OR, OP_XOR,  // bitwise
		OP_ADD, OP_SUB,  // wraps around
		OP_MUL, OP_MULH_S, OP_MULH_U,  // low half, signed high, unsigned high
		OP_SHL, OP_SHR, OP_SRA,
		OP_LIT,  // low half of a, zero extended
		OP_RD, OP_RDS, OP_RDX,  // read data zero ext, sign ext, over low half of a
		OP_RTN  // return pc
	} op_e;

	// logical unit sub-op
	typedef enum logic [1:0] {
		LG_AND, LG_OR, LG_XOR, LG_NOT
	} lg_op_e;

	// multiply / shift unit sub-op
	typedef enum logic [2:0] {
		MS_MUL, MS_MULH_S, MS_MULH_U, MS_SHL, MS_SHR, MS_SRA
	} ms_op_e;

	// result mux controls
	typedef struct packed {
		logic ms;  // stage d, take multiply/shift result
		logic rtn;  // stage b, take pc
		logic rd;  // stage c, take read data
		logic dm;  // stage a, take literal low half
		logic as;  // stage a, take add/sub result
		logic ext;  // read data goes to upper half
		logic sgn;  // read data sign extended
	} alu_ctrl_t;

	typedef struct packed {
		lg_op_e lg;
		logic sub;  // 1 = a - b
	} lgas_op_t;

	typedef struct packed {
		ms_op_e op;
	} ms_op_t;

endpackage

`default_nettype wire

/* source/vector_sr.sv */
// delays a vector by REGS clocks, REGS of zero is a plain wire and then ignores clock and reset
`timescale 1ns/1ps
`default_nettype none

module vector_sr #(
	parameter int unsigned REGS = 1,  // delay in clocks
	parameter int unsigned DATA_W = 8,
	parameter logic [DATA_W-1:0] RESET_VAL = '0
) (
	input wire clk_i,
	input wire arst_n_i,  // async, active low
	input wire [DATA_W-1:0] data_i,
	output logic [DATA_W-1:0] data_o
);

	if (REGS == 0) begin : g_wire
		assign data_o = data_i;
	end else begin : g_regs
		logic [DATA_W-1:0] stage_q [REGS];  // stage_q[0] is nearest the input

		always_ff @(posedge clk_i or negedge arst_n_i) begin
			if (!arst_n_i) begin
				for (int i = 0; i < REGS; i++) begin
					stage_q[i] <= RESET_VAL;
				end
			end else begin
				stage_q[0] <= data_i;
				for (int i = 1; i < REGS; i++) begin
					stage_q[i] <= stage_q[i-1];  // shift along
				end
			end
		end

		assign data_o = stage_q[REGS-1];
	end

endmodule

`default_nettype wire

/* source/alu_decode.sv */
// purely combinational, read ops also set the literal select so RDX keeps a's low half
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
	input wire alu_pkg::op_e op_i,
	output alu_pkg::alu_ctrl_t ctrl_o,  // to result mux
	output alu_pkg::lgas_op_t lgas_op_o,  // to logical / add-sub unit
	output alu_pkg::ms_op_t ms_op_o  // to multiply / shift unit
);

	always_comb begin
		// defaults select the logical result
		ctrl_o = '0;
		lgas_op_o.lg = alu_pkg::LG_AND;
		lgas_op_o.sub = 1'b0;
		ms_op_o.op = alu_pkg::MS_MUL;

		case (op_i)
			alu_pkg::OP_AND : lgas_op_o.lg = alu_pkg::LG_AND;
			alu_pkg::OP_OR : lgas_op_o.lg = alu_pkg::LG_OR;
			alu_pkg::OP_XOR : lgas_op_o.lg = alu_pkg::LG_XOR;
			alu_pkg::OP_ADD : ctrl_o.as = 1'b1;
			alu_pkg::OP_SUB : begin
				ctrl_o.as = 1'b1;
				lgas_op_o.sub = 1'b1;
			end
			alu_pkg::OP_MUL : ctrl_o.ms = 1'b1;  // sub-op default is MS_MUL
			alu_pkg::OP_MULH_S : begin
				ctrl_o.ms = 1'b1;
				ms_op_o.op = alu_pkg::MS_MULH_S;
			end
			alu_pkg::OP_MULH_U : begin
				ctrl_o.ms = 1'b1;
				ms_op_o.op = alu_pkg::MS_MULH_U;
			end
			alu_pkg::OP_SHL : begin
				ctrl_o.ms = 1'b1;
				ms_op_o.op = alu_pkg::MS_SHL;
			end
			alu_pkg::OP_SHR : begin
				ctrl_o.ms = 1'b1;
				ms_op_o.op = alu_pkg::MS_SHR;
			end
			alu_pkg::OP_SRA : begin
				ctrl_o.ms = 1'b1;
				ms_op_o.op = alu_pkg::MS_SRA;
			end
			alu_pkg::OP_LIT : ctrl_o.dm = 1'b1;  // literal only, no read
			alu_pkg::OP_RD : begin
				ctrl_o.dm = 1'b1;
				ctrl_o.rd = 1'b1;
			end
			alu_pkg::OP_RDS : begin
				ctrl_o.dm = 1'b1;
				ctrl_o.rd = 1'b1;
				ctrl_o.sgn = 1'b1;
			end
			alu_pkg::OP_RDX : begin
				ctrl_o.dm = 1'b1;  // low half of a carried to stage c
				ctrl_o.rd = 1'b1;
				ctrl_o.ext = 1'b1;
			end
			alu_pkg::OP_RTN : ctrl_o.rtn = 1'b1;
			default : ctrl_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/alu_lgas.sv */
// one cycle from operands to both results, add and subtract wrap around at DATA_W bits
`timescale 1ns/1ps
`default_nettype none

module alu_lgas #(
	parameter int unsigned DATA_W = 32
) (
	input wire clk_i,
	input wire arst_n_i,  // async, active low
	input wire [DATA_W-1:0] a_i,
	input wire [DATA_W-1:0] b_i,
	input wire alu_pkg::lgas_op_t op_i,
	output logic [DATA_W-1:0] res_lg_o,  // registered bitwise result
	output logic [DATA_W-1:0] res_as_o  // registered sum / difference
);

	logic [DATA_W-1:0] lg_d;  // bitwise result before the register
	logic [DATA_W-1:0] as_d;  // add/sub result before the register

	// bitwise functions
	always_comb begin
		case (op_i.lg)
			alu_pkg::LG_AND : lg_d = a_i & b_i;
			alu_pkg::LG_OR : lg_d = a_i | b_i;
			alu_pkg::LG_XOR : lg_d = a_i ^ b_i;
			alu_pkg::LG_NOT : lg_d = ~a_i;  // b ignored
			default : lg_d = '0;
		endcase
	end

	// add or subtract, carry out dropped
	always_comb begin
		if (op_i.sub) begin
			as_d = a_i - b_i;
		end else begin
			as_d = a_i + b_i;
		end
	end

	// output registers, line up with mux stage a
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res_lg_o <= '0;
			res_as_o <= '0;
		end else begin
			res_lg_o <= lg_d;
			res_as_o <= as_d;
		end
	end

endmodule

`default_nettype wire

/* source/alu_ms.sv */
// two cycles from operands to result, shift amount is b mod DATA_W, DATA_W a power of two
`timescale 1ns/1ps
`default_nettype none

module alu_ms #(
	parameter int unsigned DATA_W = 32
) (
	input wire clk_i,
	input wire arst_n_i,  // async, active low
	input wire [DATA_W-1:0] a_i,
	input wire [DATA_W-1:0] b_i,
	input wire alu_pkg::ms_op_t op_i,
	output logic [DATA_W-1:0] res_ms_o  // registered multiply / shift result
);

	localparam int unsigned SH_W = $clog2(DATA_W);  // shift amount bits

	logic sgn;  // signed multiply
	logic [2*DATA_W-1:0] a_ext, b_ext;  // operands widened for the full product
	logic [2*DATA_W-1:0] prod_d, prod_q;  // full product
	logic [SH_W-1:0] shamt;
	logic [DATA_W-1:0] shift_d, shift_q;
	alu_pkg::ms_op_t op_q;  // sub-op for stage two

	// one multiplier covers signed and unsigned
	assign sgn = (op_i.op == alu_pkg::MS_MULH_S);
	assign a_ext = {{DATA_W{sgn & a_i[DATA_W-1]}}, a_i};
	assign b_ext = {{DATA_W{sgn & b_i[DATA_W-1]}}, b_i};
	assign prod_d = a_ext * b_ext;  // modulo 2^(2*DATA_W), so sign extension gives signed product

	assign shamt = b_i[SH_W-1:0];

	always_comb begin
		case (op_i.op)
			alu_pkg::MS_SHL : shift_d = a_i << shamt;
			alu_pkg::MS_SHR : shift_d = a_i >> shamt;  // zero fill
			alu_pkg::MS_SRA : shift_d = $signed(a_i) >>> shamt;  // sign fill
			default : shift_d = a_i;  // multiply ops, unused
		endcase
	end

	// stage one
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prod_q <= '0;
			shift_q <= '0;
			op_q <= '0;
		end else begin
			prod_q <= prod_d;
			shift_q <= shift_d;
			op_q <= op_i;
		end
	end

	// stage two picks the half or the shift result
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res_ms_o <= '0;
		end else begin
			case (op_q.op)
				alu_pkg::MS_MUL : res_ms_o <= prod_q[DATA_W-1:0];
				alu_pkg::MS_MULH_S,
				alu_pkg::MS_MULH_U : res_ms_o <= prod_q[2*DATA_W-1:DATA_W];
				default : res_ms_o <= shift_q;  // all shifts
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/alu_mux.sv */
// unit results due at mux a after REGS_IN_A clocks, at mux d after REGS_IN_A through REGS_C_D
`timescale 1ns/1ps
`default_nettype none

module alu_mux #(
	parameter int unsigned REGS_IN_A = 1,  // input to mux a
	parameter int unsigned REGS_A_B = 0,  // mux a to mux b
	parameter int unsigned REGS_B_C = 0,  // mux b to mux c
	parameter int unsigned REGS_C_D = 1,  // mux c to mux d
	parameter int unsigned REGS_D_OUT = 1,  // mux d to output
	parameter int unsigned DATA_W = 32,  // even
	parameter int unsigned ADDR_W = 16  // no larger than DATA_W
) (
	input wire clk_i,
	input wire arst_n_i,  // async, active low
	input wire alu_pkg::alu_ctrl_t ctrl_i,
	input wire [DATA_W/2-1:0] a_lo_i,  // literal
	input wire [DATA_W-1:0] res_lg_i,
	input wire [DATA_W-1:0] res_as_i,
	input wire [DATA_W-1:0] res_ms_i,
	input wire [DATA_W/2-1:0] dm_data_i,  // read data, sampled at stage c
	input wire [ADDR_W-1:0] pc_i,  // sampled at stage b
	output logic [DATA_W-1:0] result_o
);

	localparam int unsigned CTRL_W = $bits(alu_pkg::alu_ctrl_t);

	alu_pkg::alu_ctrl_t ctrl_a;  // all controls at stage a
	logic [DATA_W/2-1:0] a_lo_a;
	logic ms_b, rtn_b, rd_b, ext_b, sgn_b;
	logic ms_c, rd_c, ext_c, sgn_c;
	logic ms_d;
	logic [DATA_W-1:0] mux_a, mux_b, mux_c, mux_d;
	logic [DATA_W-1:0] mux_a_b, mux_b_c, mux_c_d;  // stage outputs after the optional regs

	vector_sr #(
		.REGS(REGS_IN_A),
		.DATA_W(DATA_W/2 + CTRL_W),
		.RESET_VAL('0)
	) in_a_regs (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.data_i({a_lo_i, ctrl_i}),
		.data_o({a_lo_a, ctrl_a})
	);

	// literal wins over add/sub
	always_comb begin
		if (ctrl_a.dm) begin
			mux_a = DATA_W'(a_lo_a);
		end else if (ctrl_a.as) begin
			mux_a = res_as_i;
		end else begin
			mux_a = res_lg_i;
		end
	end

	vector_sr #(
		.REGS(REGS_A_B),
		.DATA_W(DATA_W + 5),  // dm, as consumed
		.RESET_VAL('0)
	) a_b_regs (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.data_i({mux_a, ctrl_a.ms, ctrl_a.rtn, ctrl_a.rd, ctrl_a.ext, ctrl_a.sgn}),
		.data_o({mux_a_b, ms_b, rtn_b, rd_b, ext_b, sgn_b})
	);

	assign mux_b = rtn_b ? DATA_W'(pc_i) : mux_a_b;  // pc zero extended

	vector_sr #(
		.REGS(REGS_B_C),
		.DATA_W(DATA_W + 4),  // rtn consumed
		.RESET_VAL('0)
	) b_c_regs (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.data_i({mux_b, ms_b, rd_b, ext_b, sgn_b}),
		.data_o({mux_b_c, ms_c, rd_c, ext_c, sgn_c})
	);

	// read data placement
	always_comb begin
		casez ({rd_c, ext_c, sgn_c})
			3'b100 : mux_c = DATA_W'(dm_data_i);
			3'b101 : mux_c = DATA_W'($signed(dm_data_i));
			3'b11? : mux_c = {dm_data_i, mux_b_c[DATA_W/2-1:0]};  // over carried literal
			default : mux_c = mux_b_c;  // no read
		endcase
	end

	vector_sr #(
		.REGS(REGS_C_D),
		.DATA_W(DATA_W + 1),
		.RESET_VAL('0)
	) c_d_regs (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.data_i({mux_c, ms_c}),
		.data_o({mux_c_d, ms_d})
	);

	assign mux_d = ms_d ? res_ms_i : mux_c_d;  // multiply/shift arrives last

	vector_sr #(
		.REGS(REGS_D_OUT),
		.DATA_W(DATA_W),
		.RESET_VAL('0)
	) d_out_regs (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.data_i(mux_d),
		.data_o(result_o)
	);

endmodule

`default_nettype wire

/* source/alu_core.sv */
// fixed 3-cycle latency with default regs, pc and read data for an op are due one cycle after it
`timescale 1ns/1ps
`default_nettype none

module alu_core #(
	parameter int unsigned DATA_W = alu_pkg::DATA_W_DEF,  // even, power of two
	parameter int unsigned ADDR_W = alu_pkg::ADDR_W_DEF,  // pc width
	parameter int unsigned REGS_IN_A = 1,  // matches alu_lgas latency
	parameter int unsigned REGS_A_B = 0,
	parameter int unsigned REGS_B_C = 0,
	parameter int unsigned REGS_C_D = 1,  // with the above, matches alu_ms latency
	parameter int unsigned REGS_D_OUT = 1
) (
	input wire clk_i,
	input wire arst_n_i,  // async, active low
	input wire alu_pkg::op_e op_i,
	input wire [DATA_W-1:0] a_i,
	input wire [DATA_W-1:0] b_i,
	input wire [DATA_W/2-1:0] dm_data_i,
	input wire [ADDR_W-1:0] pc_i,
	output logic [DATA_W-1:0] result_o
);

	alu_pkg::alu_ctrl_t ctrl;
	alu_pkg::lgas_op_t lgas_op;
	alu_pkg::ms_op_t ms_op;
	logic [DATA_W-1:0] res_lg, res_as, res_ms;  // unit results

	alu_decode alu_decode_i (
		.op_i(op_i),
		.ctrl_o(ctrl),
		.lgas_op_o(lgas_op),
		.ms_op_o(ms_op)
	);

	alu_lgas #(
		.DATA_W(DATA_W)
	) alu_lgas_i (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.a_i(a_i),
		.b_i(b_i),
		.op_i(lgas_op),
		.res_lg_o(res_lg),
		.res_as_o(res_as)
	);

	alu_ms #(
		.DATA_W(DATA_W)
	) alu_ms_i (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.a_i(a_i),
		.b_i(b_i),
		.op_i(ms_op),
		.res_ms_o(res_ms)
	);

	alu_mux #(
		.REGS_IN_A(REGS_IN_A),
		.REGS_A_B(REGS_A_B),
		.REGS_B_C(REGS_B_C),
		.REGS_C_D(REGS_C_D),
		.REGS_D_OUT(REGS_D_OUT),
		.DATA_W(DATA_W),
		.ADDR_W(ADDR_W)
	) alu_mux_i (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.ctrl_i(ctrl),
		.a_lo_i(a_i[DATA_W/2-1:0]),  // literal half
		.res_lg_i(res_lg),
		.res_as_i(res_as),
		.res_ms_i(res_ms),
		.dm_data_i(dm_data_i),
		.pc_i(pc_i),
		.result_o(result_o)
	);

endmodule

`default_nettype wire

/* tests/alu_core_tb.sv */
// default widths and register settings (3-cycle latency) only, stimulus fixed by seed 85575
`timescale 1ns/1ps
`default_nettype none

module alu_core_tb;

	localparam int DATA_W = alu_pkg::DATA_W_DEF;
	localparam int ADDR_W = alu_pkg::ADDR_W_DEF;
	localparam int SH_W = $clog2(DATA_W);  // shift amount bits
	localparam int END_LGAS = 1000;  // logical and add/sub
	localparam int END_MS = 1500;  // every shift amount first, then random multiply/shift
	localparam int END_LR = 1750;  // literal and return pc
	localparam int END_RD = 2000;  // read data ops
	localparam int N_OPS = 4000;  // rest is a random mix of all opcodes
	localparam int LATENCY = 3;
	localparam int CYCLE_LIMIT = 8 + N_OPS + LATENCY + 20;  // reset, tests, drain, margin

	logic clk_i = 1'b0;
	logic arst_n_i;
	alu_pkg::op_e op_i;
	logic [DATA_W-1:0] a_i, b_i;
	logic [DATA_W/2-1:0] dm_data_i;
	logic [ADDR_W-1:0] pc_i;
	logic [DATA_W-1:0] result_o;

	integer seed = 85575;
	int errors = 0;
	int checks = 0;
	int cycles = 0;  // posedges since start, for the timeout

	logic [DATA_W-1:0] exp_q[$];  // expected results in issue order
	alu_pkg::op_e op_q[$];  // matching opcodes, for error lines
	alu_pkg::op_e pend_op, op_n, chk_op;
	logic [DATA_W-1:0] pend_a, pend_b, a_n, b_n;
	logic pend_vld = 1'b0;  // op waiting for its pc / read data
	logic [DATA_W/2-1:0] dm_n;
	logic [ADDR_W-1:0] pc_n;

	alu_core alu_core_i (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.op_i(op_i),
		.a_i(a_i),
		.b_i(b_i),
		.dm_data_i(dm_data_i),
		.pc_i(pc_i),
		.result_o(result_o)
	);

	always #4 clk_i = ~clk_i;  // 8 ns period

	// compares one result, counts and reports a mismatch
	task automatic check_value(input string what, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s gave 0x%h, expected 0x%h", $time, what, got, exp);
		end
	endtask

	// reference model of one op, dm and pc are the values driven the cycle after it
	function automatic logic [DATA_W-1:0] model_result(input alu_pkg::op_e op,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			input logic [DATA_W/2-1:0] dm, input logic [ADDR_W-1:0] pc);
		logic signed [2*DATA_W-1:0] prod_s;
		logic [2*DATA_W-1:0] prod_u;
		logic [SH_W-1:0] sh;
		prod_s = $signed(a) * $signed(b);  // both widened to 2*DATA_W with sign
		prod_u = a * b;
		sh = b[SH_W-1:0];
		case (op)
			alu_pkg::OP_AND : return a & b;
			alu_pkg::OP_OR : return a | b;
			alu_pkg::OP_XOR : return a ^ b;
			alu_pkg::OP_ADD : return a + b;  // wraps
			alu_pkg::OP_SUB : return a - b;
			alu_pkg::OP_MUL : return prod_u[DATA_W-1:0];
			alu_pkg::OP_MULH_S : return prod_s[2*DATA_W-1:DATA_W];
			alu_pkg::OP_MULH_U : return prod_u[2*DATA_W-1:DATA_W];
			alu_pkg::OP_SHL : return a << sh;
			alu_pkg::OP_SHR : return a >> sh;
			alu_pkg::OP_SRA : return $signed(a) >>> sh;
			alu_pkg::OP_LIT : return {{(DATA_W/2){1'b0}}, a[DATA_W/2-1:0]};
			alu_pkg::OP_RD : return {{(DATA_W/2){1'b0}}, dm};
			alu_pkg::OP_RDS : return {{(DATA_W/2){dm[DATA_W/2-1]}}, dm};
			alu_pkg::OP_RDX : return {dm, a[DATA_W/2-1:0]};
			alu_pkg::OP_RTN : return DATA_W'(pc);  // zero extended
			default : return '0;
		endcase
	endfunction

	// opcode and operands for issue slot i, opcode range depends on the test phase
	task automatic next_operands(input int i, output alu_pkg::op_e op,
			output logic [DATA_W-1:0] a, output logic [DATA_W-1:0] b);
		int unsigned r;
		int k;
		r = $unsigned($random(seed));
		a = DATA_W'($random(seed));
		b = DATA_W'($random(seed));
		k = i - END_LGAS;
		if (i < END_MS) begin
			if ((r >> 8) % 8 == 0) a = '1;  // corner operands for carries and products
			if ((r >> 12) % 8 == 0) b = '1;
		end
		if (i < END_LGAS) begin
			op = alu_pkg::op_e'(alu_pkg::OP_AND + r % 5);
		end else if (i < END_MS && k < 3 * DATA_W) begin
			op = alu_pkg::op_e'(alu_pkg::OP_SHL + k / DATA_W);  // SHL, SHR, SRA in turn
			b = {b[DATA_W-1:SH_W], SH_W'(k % DATA_W)};  // every amount once per shift
		end else if (i < END_MS) begin
			op = alu_pkg::op_e'(alu_pkg::OP_MUL + r % 6);
		end else if (i < END_LR) begin
			op = (r % 2) ? alu_pkg::OP_RTN : alu_pkg::OP_LIT;
		end else if (i < END_RD) begin
			op = alu_pkg::op_e'(alu_pkg::OP_RD + r % 3);
		end else begin
			op = alu_pkg::op_e'(r % 16);
		end
	endtask

	// run limit
	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: no verdict after %0d clock cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		arst_n_i = 1'b0;
		op_i = alu_pkg::OP_AND;
		a_i = '0;
		b_i = '0;
		dm_data_i = '0;
		pc_i = '0;
		repeat (8) @(posedge clk_i);
		arst_n_i <= 1'b1;

		// back-to-back issue, one op per cycle, plus drain
		for (int t = 0; t < N_OPS + LATENCY; t++) begin
			@(posedge clk_i);
			dm_n = (DATA_W/2)'($random(seed));  // belongs to the op issued last cycle
			pc_n = ADDR_W'($random(seed));
			dm_data_i <= dm_n;
			pc_i <= pc_n;
			if (pend_vld) begin
				exp_q.push_back(model_result(pend_op, pend_a, pend_b, dm_n, pc_n));
				op_q.push_back(pend_op);
			end
			pend_vld = (t < N_OPS);
			if (t < N_OPS) begin
				next_operands(t, op_n, a_n, b_n);
				pend_op = op_n;
				pend_a = a_n;
				pend_b = b_n;
			end else begin
				op_n = alu_pkg::OP_AND;  // drain, not checked
				a_n = '0;
				b_n = '0;
			end
			op_i <= op_n;
			a_i <= a_n;
			b_i <= b_n;

			@(negedge clk_i);  // result_o stable mid cycle
			if (t < LATENCY) begin
				check_value("result after reset", result_o, '0);
			end else begin
				chk_op = op_q.pop_front();
				check_value(chk_op.name(), result_o, exp_q.pop_front());
			end
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
source/alu_pkg.sv
source/vector_sr.sv
source/alu_decode.sv
source/alu_lgas.sv
source/alu_ms.sv
source/alu_mux.sv
source/alu_core.sv
tests/alu_core_tb.sv
